//--- hdl/dmm_pkg.sv
//////////////////////////////
// shared widths, spi register map, cs codes and output vector layout
// output vector offsets follow the board pinout, 24 bits used
//////////////////////////////
`default_nettype none

package dmm_pkg;

  //////////////////////////////
  // spi frame
  localparam int REG_W      = 32;
  localparam int ADDR_W     = 7;
  localparam int FRAME_BITS = 1 + ADDR_W + REG_W;   // wr flag, addr, data

  // cs vector from the mcu, decimal codes
  localparam int              CS_W        = 3;
  localparam logic [CS_W-1:0] CS_DEASSERT = 3'd0;
  localparam logic [CS_W-1:0] CS_FPGA0    = 3'd1;   // this register set
  localparam logic [CS_W-1:0] CS_4094     = 3'd2;
  localparam logic [CS_W-1:0] CS_MDAC0    = 3'd3;
  localparam logic [CS_W-1:0] CS_MDAC1    = 3'd4;

  // register addresses
  localparam logic [ADDR_W-1:0] REG_4094_OE      = 7'h09;
  localparam logic [ADDR_W-1:0] REG_MODE         = 7'h0c;
  localparam logic [ADDR_W-1:0] REG_DIRECT       = 7'h0d;
  localparam logic [ADDR_W-1:0] REG_STATUS       = 7'h0e;   // read only
  localparam logic [ADDR_W-1:0] REG_SA_PRECHARGE = 7'h10;
  localparam logic [ADDR_W-1:0] REG_SA_SEQ_N     = 7'h11;
  localparam logic [ADDR_W-1:0] REG_SA_SEQ0      = 7'h12;
  localparam logic [ADDR_W-1:0] REG_SA_SEQ1      = 7'h13;
  localparam logic [ADDR_W-1:0] REG_SA_SEQ2      = 7'h14;
  localparam logic [ADDR_W-1:0] REG_SA_SEQ3      = 7'h15;
  localparam logic [ADDR_W-1:0] REG_ADC_APERTURE = 7'h16;

  // output modes
  localparam int                MODE_W       = 3;
  localparam logic [MODE_W-1:0] MODE_DIRECT  = 3'd0;
  localparam logic [MODE_W-1:0] MODE_SA_MOCK = 3'd6;   // sequencer + mock adc

  //////////////////////////////
  // sequence acquisition
  localparam int SEQ_ENTRIES = 4;
  localparam int SEQ_N_W     = 3;
  localparam int SEQ_ENTRY_W = 6;    // {pc_sw[1:0], azmux[3:0]}
  localparam int PRECHARGE_W = 24;

  localparam int                 SA_ST_W      = 2;
  localparam logic [SA_ST_W-1:0] SA_IDLE      = 2'd0;
  localparam logic [SA_ST_W-1:0] SA_PRECHARGE = 2'd1;
  localparam logic [SA_ST_W-1:0] SA_MEASURE   = 2'd2;

  // output vector, leds and monitor lowest
  localparam int OUT_W             = 24;
  localparam int LEDS_LSB          = 0;    // 4
  localparam int MONITOR_LSB       = 4;    // 8
  localparam int PC_SW_LSB         = 12;   // 2
  localparam int AZMUX_LSB         = 14;   // 4
  localparam int ADC_REFMUX_LSB    = 18;   // 2
  localparam int ADC_RSTMUX_BIT    = 20;
  localparam int ADC_SIGMUX_BIT    = 21;
  localparam int CMPR_LATCH_BIT    = 22;
  localparam int SPI_INTERRUPT_BIT = 23;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

endpackage

`default_nettype wire

//--- hdl/sa_params_if.sv
//////////////////////////////
// acquisition parameters, clk domain
// static between spi writes; software writes them only while trig is low
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface sa_params_if;
  import dmm_pkg::*;

  logic [PRECHARGE_W-1:0] precharge;                  // hold per entry, clk cycles
  logic [SEQ_N_W-1:0]     seq_n;                      // entries in use, 1..4
  logic [SEQ_ENTRY_W-1:0] seq_entry [SEQ_ENTRIES];    // {pc_sw, azmux}
  logic [REG_W-1:0]       aperture;                   // mock adc, clk cycles

  // register set owns everything
  modport regs (
    output precharge,
    output seq_n,
    output seq_entry,
    output aperture
  );

  modport seq (input precharge, input seq_n, input seq_entry);

  modport adc (input aperture);

endinterface

`default_nettype wire

//--- hdl/spi_port.sv
//////////////////////////////
// spi slave + bus router. pins oversampled, needs clk >= 8x sck
// mode 0 frames: wr flag, 7b addr, 32b data. write commits at 40 bits
// routing outputs are combinational from the pins
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module spi_port (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       sck_i,
  input  logic                       sdi_i,
  input  logic [dmm_pkg::CS_W-1:0]   cs_vec_i,
  input  logic                       spi_4094_miso_i,
  input  logic [3:0]                 hw_flags_i,
  input  logic [2:0]                 sample_idx_last_i,
  output logic                       sdo_o,
  output logic                       spi_glb_clk_o,
  output logic                       spi_glb_mosi_o,
  output logic                       spi_4094_strobe_o,
  output logic                       spi_cs_dac_o,
  output logic                       spi_cs_iso_o,
  output logic                       spi_4094_oe_o,
  output logic [dmm_pkg::MODE_W-1:0] mode_o,
  output logic [dmm_pkg::OUT_W-1:0]  direct_o,
  sa_params_if.regs                  params
);
  import dmm_pkg::*;

  logic                  sck_meta;
  logic                  sck_s;
  logic                  sck_d;       // edge detect
  logic                  sdi_meta;
  logic                  sdi_s;
  logic [CS_W-1:0]       cs_meta;
  logic [CS_W-1:0]       cs_s;
  logic                  sel_d;
  logic                  sel;
  logic                  frame_start;
  logic                  frame_end;
  logic                  commit;
  logic [5:0]            bit_cnt;     // saturates
  logic [FRAME_BITS-1:0] sh_in;
  logic [REG_W-1:0]      sout;        // miso shift out
  logic [REG_W-1:0]      rd_word;
  logic [REG_W-1:0]      status;

  //////////////////////////////
  // bus routing, straight from pins
  assign spi_glb_clk_o     = (cs_vec_i == CS_FPGA0) ? 1'b1 : sck_i;   // park hi
  assign spi_glb_mosi_o    = (cs_vec_i == CS_FPGA0) ? 1'b1 : sdi_i;   // park hi
  assign spi_4094_strobe_o = (cs_vec_i == CS_4094);                   // active hi
  assign spi_cs_dac_o      = (cs_vec_i != CS_MDAC0);                  // active lo
  assign spi_cs_iso_o      = (cs_vec_i != CS_MDAC1);                  // active lo
  assign sdo_o = (cs_vec_i == CS_FPGA0) ? sout[REG_W-1] : spi_4094_miso_i;

  //////////////////////////////
  // two-flop sync of sck, sdi, cs
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sck_meta <= 1'b0;
      sck_s    <= 1'b0;
      sck_d    <= 1'b0;
      sdi_meta <= 1'b0;
      sdi_s    <= 1'b0;
      cs_meta  <= CS_DEASSERT;
      cs_s     <= CS_DEASSERT;
      sel_d    <= 1'b0;
    end else begin
      sck_meta <= sck_i;
      sck_s    <= sck_meta;
      sck_d    <= sck_s;
      sdi_meta <= sdi_i;
      sdi_s    <= sdi_meta;
      cs_meta  <= cs_vec_i;
      cs_s     <= cs_meta;
      sel_d    <= sel;
    end
  end

  assign sel         = (cs_s == CS_FPGA0);
  assign frame_start = sel & ~sel_d;
  assign frame_end   = ~sel & sel_d;
  assign commit      = frame_end && (bit_cnt == FRAME_BITS) && sh_in[FRAME_BITS-1];

  // bit count and miso. read word goes out after the address byte
  always_ff @(posedge clk_i) begin
    if (reset_i || frame_start) begin
      bit_cnt <= '0;
      sout    <= '0;
    end else if (sel) begin
      if (sck_s && !sck_d && bit_cnt != '1) bit_cnt <= bit_cnt + 1'b1;
      if (!sck_s && sck_d) begin
        if (bit_cnt == ADDR_W + 1) sout <= rd_word;
        else sout <= {sout[REG_W-2:0], 1'b0};
      end
    end
  end

  // mosi shift, master drives on falling so sdi settled at rising
  always_ff @(posedge clk_i) begin
    if (sel && sck_s && !sck_d) sh_in <= {sh_in[FRAME_BITS-2:0], sdi_s};
  end

  //////////////////////////////
  // status: 0, seq_n, 0, idx last, 0, flags, magic
  assign status = {8'h00, 1'b0, params.seq_n, 1'b0, sample_idx_last_i,
                   4'h0, hw_flags_i, STATUS_MAGIC};

  always_comb begin
    case (sh_in[ADDR_W-1:0])   // address byte just shifted in
      REG_4094_OE:      rd_word = REG_W'(spi_4094_oe_o);
      REG_MODE:         rd_word = REG_W'(mode_o);
      REG_DIRECT:       rd_word = REG_W'(direct_o);
      REG_STATUS:       rd_word = status;
      REG_SA_PRECHARGE: rd_word = REG_W'(params.precharge);
      REG_SA_SEQ_N:     rd_word = REG_W'(params.seq_n);
      REG_SA_SEQ0:      rd_word = REG_W'(params.seq_entry[0]);
      REG_SA_SEQ1:      rd_word = REG_W'(params.seq_entry[1]);
      REG_SA_SEQ2:      rd_word = REG_W'(params.seq_entry[2]);
      REG_SA_SEQ3:      rd_word = REG_W'(params.seq_entry[3]);
      REG_ADC_APERTURE: rd_word = params.aperture;
      default:          rd_word = '0;
    endcase
  end

  // register file, truncating writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      spi_4094_oe_o    <= 1'b0;   // 4094 outputs off at power up
      mode_o           <= MODE_DIRECT;
      direct_o         <= '0;
      params.precharge <= '0;
      params.seq_n     <= '0;
      params.aperture  <= '0;
      for (int i = 0; i < SEQ_ENTRIES; i++) params.seq_entry[i] <= '0;
    end else if (commit) begin
      case (sh_in[REG_W +: ADDR_W])
        REG_4094_OE:      spi_4094_oe_o        <= sh_in[0];
        REG_MODE:         mode_o               <= sh_in[MODE_W-1:0];
        REG_DIRECT:       direct_o             <= sh_in[OUT_W-1:0];
        REG_SA_PRECHARGE: params.precharge     <= sh_in[PRECHARGE_W-1:0];
        REG_SA_SEQ_N:     params.seq_n         <= sh_in[SEQ_N_W-1:0];
        REG_SA_SEQ0:      params.seq_entry[0]  <= sh_in[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ1:      params.seq_entry[1]  <= sh_in[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ2:      params.seq_entry[2]  <= sh_in[SEQ_ENTRY_W-1:0];
        REG_SA_SEQ3:      params.seq_entry[3]  <= sh_in[SEQ_ENTRY_W-1:0];
        REG_ADC_APERTURE: params.aperture      <= sh_in[REG_W-1:0];
        default:          ;   // status and unmapped ignored
      endcase
    end
  end

  // a register only moves the cycle after a full 40-bit frame ends
  a_full_frame: assert property (@(posedge clk_i) disable iff (reset_i)
    !$stable({mode_o, direct_o, params.aperture, params.precharge}) |->
      $past(frame_end && bit_cnt == FRAME_BITS));

endmodule

`default_nettype wire

//--- hdl/sequence_acquisition.sv
//////////////////////////////
// azero / precharge sequencer, one entry per sample
// trig low holds it idle; seq_n must be 1..4 while trig is high
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sequence_acquisition (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       trig_i,
  input  logic       adc_measure_valid_i,
  output logic       adc_reset_n_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [2:0] sample_idx_last_o,
  sa_params_if.seq   params
);
  import dmm_pkg::*;

  logic [SA_ST_W-1:0]             state;
  logic [PRECHARGE_W-1:0]         cnt;
  logic [$clog2(SEQ_ENTRIES)-1:0] idx;
  logic [$clog2(SEQ_ENTRIES)-1:0] idx_next;

  // wrap after seq_n entries
  assign idx_next = ({1'b0, idx} + 3'd1 >= params.seq_n) ? '0 : idx + 1'b1;

  assign leds_o    = 4'b0001 << idx;                                  // one-hot idx
  assign monitor_o = {azmux_o, pc_sw_o, adc_measure_valid_i, adc_reset_n_o};

  //////////////////////////////
  // idle -> precharge -> measure -> precharge ...
  always_ff @(posedge clk_i) begin
    if (reset_i || !trig_i) begin
      state         <= SA_IDLE;
      cnt           <= '0;
      idx           <= '0;
      adc_reset_n_o <= 1'b0;   // adc held
      pc_sw_o       <= '0;
      azmux_o       <= '0;
    end else begin
      case (state)
        SA_IDLE: begin
          {pc_sw_o, azmux_o} <= params.seq_entry[idx];   // first entry
          cnt                <= '0;
          state              <= SA_PRECHARGE;
        end
        SA_PRECHARGE: begin
          if (cnt + 1'b1 >= params.precharge) begin
            adc_reset_n_o <= 1'b1;   // release adc, sample starts
            state         <= SA_MEASURE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        SA_MEASURE: begin
          if (adc_measure_valid_i) begin
            adc_reset_n_o      <= 1'b0;
            idx                <= idx_next;
            {pc_sw_o, azmux_o} <= params.seq_entry[idx_next];
            cnt                <= '0;
            state              <= SA_PRECHARGE;
          end
        end
        default: state <= SA_IDLE;
      endcase
    end
  end

  // last completed sample, kept across trig for status readout
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sample_idx_last_o <= '0;
    end else if (trig_i && state == SA_MEASURE && adc_measure_valid_i) begin
      sample_idx_last_o <= {1'b0, idx};
    end
  end

  // register set must hold a usable count before trig
  a_seq_n_range: assert property (@(posedge clk_i) disable iff (reset_i)
    trig_i |-> (params.seq_n >= 1 && params.seq_n <= SEQ_ENTRIES));

  // adc only finishes a sample we started
  a_valid_in_measure: assert property (@(posedge clk_i) disable iff (reset_i || !trig_i)
    adc_measure_valid_i |-> state == SA_MEASURE);

endmodule

`default_nettype wire

//--- hdl/adc_mock.sv
//////////////////////////////
// stand-in for the adc. valid pulses aperture+1 clks after reset_n rises
// one pulse per reset release
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module adc_mock (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     adc_reset_n_i,
  output logic     adc_measure_valid_o,
  sa_params_if.adc params
);
  import dmm_pkg::*;

  logic [REG_W-1:0] cnt;    // aperture counter
  logic             done;   // blocks a second pulse

  always_ff @(posedge clk_i) begin
    if (reset_i || !adc_reset_n_i) begin
      cnt                 <= '0;
      done                <= 1'b0;
      adc_measure_valid_o <= 1'b0;
    end else begin
      adc_measure_valid_o <= 1'b0;   // single cycle
      if (!done) begin
        if (cnt == params.aperture) begin
          adc_measure_valid_o <= 1'b1;
          done                <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/output_mode_mux.sv
//////////////////////////////
// registered output vector select, one clk latency
// only direct mode drives the adc fields
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module output_mode_mux (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [dmm_pkg::MODE_W-1:0] mode_i,
  input  logic [dmm_pkg::OUT_W-1:0]  direct_i,
  input  logic [3:0]                 sa_leds_i,
  input  logic [7:0]                 sa_monitor_i,
  input  logic [1:0]                 sa_pc_sw_i,
  input  logic [3:0]                 sa_azmux_i,
  input  logic                       adc_measure_valid_i,
  output logic [dmm_pkg::OUT_W-1:0]  outputs_o
);
  import dmm_pkg::*;

  logic [OUT_W-1:0] sa_vec;     // mode 6 layout
  logic [OUT_W-1:0] next_vec;

  always_comb begin
    sa_vec                        = '0;   // adc muxes, latch stay lo
    sa_vec[LEDS_LSB +: 4]         = sa_leds_i;
    sa_vec[MONITOR_LSB +: 8]      = sa_monitor_i;
    sa_vec[PC_SW_LSB +: 2]        = sa_pc_sw_i;
    sa_vec[AZMUX_LSB +: 4]        = sa_azmux_i;
    sa_vec[SPI_INTERRUPT_BIT]     = adc_measure_valid_i;   // mcu sees each sample
  end

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  next_vec = direct_i;
      MODE_SA_MOCK: next_vec = sa_vec;
      default:      next_vec = '0;   // unused modes
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) outputs_o <= '0;
    else outputs_o <= next_vec;
  end

endmodule

`default_nettype wire

//--- hdl/dmm_top.sv
//////////////////////////////
// dmm acquisition control fpga, single clock CLK
// modes 0 (direct) and 6 (sequencer + mock adc) only
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dmm_top (
  input  logic                     CLK,
  input  logic                     reset_i,
  input  logic                     SCK,
  input  logic                     sdi_i,
  output logic                     sdo_o,
  input  logic [dmm_pkg::CS_W-1:0] cs_vec_i,
  output logic                     spi_glb_clk_o,
  output logic                     spi_glb_mosi_o,
  output logic                     spi_4094_strobe_o,
  output logic                     spi_4094_oe_o,
  input  logic                     spi_4094_miso_i,
  output logic                     spi_cs_dac_o,
  output logic                     spi_cs_iso_o,
  input  logic [3:0]               hw_flags_i,
  input  logic                     trig_i,
  output logic [3:0]               leds_o,
  output logic [7:0]               monitor_o,
  output logic [1:0]               pc_sw_o,
  output logic [3:0]               azmux_o,
  output logic [1:0]               adc_refmux_o,
  output logic                     adc_rstmux_o,
  output logic                     adc_sigmux_o,
  output logic                     adc_cmpr_latch_o,
  output logic                     spi_interrupt_o
);
  import dmm_pkg::*;

  logic [MODE_W-1:0] mode;
  logic [OUT_W-1:0]  direct;
  logic [OUT_W-1:0]  outputs;
  logic [2:0]        sample_idx_last;
  logic              adc_reset_n;
  logic              adc_measure_valid;
  logic [3:0]        sa_leds;
  logic [7:0]        sa_monitor;
  logic [1:0]        sa_pc_sw;
  logic [3:0]        sa_azmux;

  sa_params_if sa_params ();

  spi_port spi_port (
    .clk_i(CLK), .reset_i(reset_i), .sck_i(SCK), .sdi_i(sdi_i), .cs_vec_i(cs_vec_i),
    .spi_4094_miso_i(spi_4094_miso_i), .hw_flags_i(hw_flags_i),
    .sample_idx_last_i(sample_idx_last), .sdo_o(sdo_o),
    .spi_glb_clk_o(spi_glb_clk_o), .spi_glb_mosi_o(spi_glb_mosi_o),
    .spi_4094_strobe_o(spi_4094_strobe_o), .spi_cs_dac_o(spi_cs_dac_o),
    .spi_cs_iso_o(spi_cs_iso_o), .spi_4094_oe_o(spi_4094_oe_o),
    .mode_o(mode), .direct_o(direct), .params(sa_params.regs)
  );

  sequence_acquisition sequence_acquisition (
    .clk_i(CLK), .reset_i(reset_i), .trig_i(trig_i),
    .adc_measure_valid_i(adc_measure_valid), .adc_reset_n_o(adc_reset_n),
    .pc_sw_o(sa_pc_sw), .azmux_o(sa_azmux), .leds_o(sa_leds), .monitor_o(sa_monitor),
    .sample_idx_last_o(sample_idx_last), .params(sa_params.seq)
  );

  adc_mock adc_mock (
    .clk_i(CLK), .reset_i(reset_i), .adc_reset_n_i(adc_reset_n),
    .adc_measure_valid_o(adc_measure_valid), .params(sa_params.adc)
  );

  output_mode_mux output_mode_mux (
    .clk_i(CLK), .reset_i(reset_i), .mode_i(mode), .direct_i(direct),
    .sa_leds_i(sa_leds), .sa_monitor_i(sa_monitor), .sa_pc_sw_i(sa_pc_sw),
    .sa_azmux_i(sa_azmux), .adc_measure_valid_i(adc_measure_valid), .outputs_o(outputs)
  );

  // output vector onto pins
  assign leds_o           = outputs[LEDS_LSB +: 4];
  assign monitor_o        = outputs[MONITOR_LSB +: 8];
  assign pc_sw_o          = outputs[PC_SW_LSB +: 2];
  assign azmux_o          = outputs[AZMUX_LSB +: 4];
  assign adc_refmux_o     = outputs[ADC_REFMUX_LSB +: 2];
  assign adc_rstmux_o     = outputs[ADC_RSTMUX_BIT];
  assign adc_sigmux_o     = outputs[ADC_SIGMUX_BIT];
  assign adc_cmpr_latch_o = outputs[CMPR_LATCH_BIT];
  assign spi_interrupt_o  = outputs[SPI_INTERRUPT_BIT];

endmodule

`default_nettype wire

//--- testbench/dmm_model.svh
//////////////////////////////
// spi master tasks, register shadow, sequencer model and compares
// included in tb_dmm_top after the dmm_pkg import and the tb signals
//////////////////////////////
`ifndef DMM_MODEL_SVH
`define DMM_MODEL_SVH

localparam int SCK_HALF = 8;   // clk cycles per sck phase so sck is clk/16

logic [REG_W-1:0] shadow [0:(1<<ADDR_W)-1];   // expected register contents
int               checks;
int               value_errors;
int               timeout_errors;

// writable bits per register as writes truncate
function automatic logic [REG_W-1:0] reg_mask(input logic [ADDR_W-1:0] addr);
  case (addr)
    REG_4094_OE:      return REG_W'(1);
    REG_MODE:         return REG_W'((1 << MODE_W) - 1);
    REG_DIRECT:       return REG_W'((1 << OUT_W) - 1);
    REG_SA_PRECHARGE: return REG_W'((1 << PRECHARGE_W) - 1);
    REG_SA_SEQ_N:     return REG_W'((1 << SEQ_N_W) - 1);
    REG_SA_SEQ0, REG_SA_SEQ1, REG_SA_SEQ2, REG_SA_SEQ3:
                      return REG_W'((1 << SEQ_ENTRY_W) - 1);
    REG_ADC_APERTURE: return '1;
    default:          return '0;   // status and holes take no write
  endcase
endfunction

//////////////////////////////
// spi mode 0 master sending msb first
task automatic shift_frame(input logic [FRAME_BITS-1:0] tx, input int nbits,
                           output logic [REG_W-1:0] rx);
  int i;
  rx = '0;
  @(posedge clk);
  cs_vec <= CS_FPGA0;
  repeat (SCK_HALF) @(posedge clk);
  for (i = 0; i < nbits; i++) begin
    sdi <= tx[FRAME_BITS-1-i];                     // mosi moves while sck low
    repeat (SCK_HALF - 1) @(posedge clk);
    @(negedge clk);
    if (i > ADDR_W) rx = {rx[REG_W-2:0], sdo};     // data bits only
    @(posedge clk);
    sck <= 1'b1;
    repeat (SCK_HALF) @(posedge clk);
    sck <= 1'b0;
  end
  repeat (SCK_HALF) @(posedge clk);
  cs_vec <= CS_DEASSERT;
  repeat (SCK_HALF) @(posedge clk);   // commit plus output register
endtask

// short frames leave the register alone
task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] data,
                         input int nbits);
  logic [REG_W-1:0] unused;
  shift_frame({1'b1, addr, data}, nbits, unused);
  if (nbits == FRAME_BITS) shadow[addr] = data & reg_mask(addr);
endtask

task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
  shift_frame({1'b0, addr, {REG_W{1'b0}}}, FRAME_BITS, data);
endtask

//////////////////////////////
// sequencer model
function automatic int next_idx(input int idx, input int seq_n);
  return (idx + 1) % seq_n;   // wrap after seq_n entries
endfunction

// output vector in mode 6 when adc_reset_n has just risen
function automatic logic [OUT_W-1:0] sample_vec(input int idx,
                                                input logic [SEQ_ENTRY_W-1:0] entry);
  logic [OUT_W-1:0] v;
  v                         = '0;   // adc pins and interrupt low
  v[LEDS_LSB + idx]         = 1'b1;
  v[MONITOR_LSB]            = 1'b1;
  v[MONITOR_LSB + 2 +: 2]   = entry[5:4];
  v[MONITOR_LSB + 4 +: 4]   = entry[3:0];
  v[PC_SW_LSB +: 2]         = entry[5:4];
  v[AZMUX_LSB +: 4]         = entry[3:0];
  return v;
endfunction

function automatic logic [REG_W-1:0] status_word(input logic [3:0] flags, input int idx_last);
  return {8'h00, 1'b0, shadow[REG_SA_SEQ_N][2:0], 1'b0, 3'(idx_last),
          4'h0, flags, STATUS_MAGIC};
endfunction

//////////////////////////////
// compares
task automatic check_word(input string name, input logic [REG_W-1:0] got, exp);
  checks++;
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_outputs(input string name, input logic [OUT_W-1:0] got, exp);
  checks++;
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, exp);
  checks++;
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
  end
endtask

`endif

//--- testbench/tb_dmm_top.sv
//////////////////////////////
// random regression for dmm_top from a fixed seed
// spi at clk/16; sequence test assumes precharge and aperture >= 2
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_dmm_top;
  import dmm_pkg::*;

  localparam logic [31:0] SEED_INIT   = 32'h4fc2_ec97;
  localparam int          SEQ_TIMEOUT = 5000;   // clk cycles for a whole sequence run
  localparam int          OUT_TIMEOUT = 50;
  localparam logic [ADDR_W-1:0] RW_REGS [10] = '{REG_4094_OE, REG_MODE, REG_DIRECT,
    REG_SA_PRECHARGE, REG_SA_SEQ_N, REG_SA_SEQ0, REG_SA_SEQ1, REG_SA_SEQ2, REG_SA_SEQ3,
    REG_ADC_APERTURE};

  logic            clk;
  logic            reset;
  logic            sck;
  logic            sdi;
  logic            sdo;
  logic [CS_W-1:0] cs_vec;
  logic            miso_4094;
  logic [3:0]      hw_flags;
  logic            trig;
  logic            glb_clk, glb_mosi, strobe, oe_4094, cs_dac, cs_iso;
  logic [3:0]      leds;
  logic [7:0]      monitor;
  logic [1:0]      pc_sw;
  logic [3:0]      azmux;
  logic [1:0]      refmux;
  logic            rstmux, sigmux, cmpr_latch, irq;
  logic [OUT_W-1:0] pins;   // pins regathered into the output vector
  integer          seed;

  `include "dmm_model.svh"

  dmm_top DUT (
    .CLK(clk), .reset_i(reset), .SCK(sck), .sdi_i(sdi), .sdo_o(sdo), .cs_vec_i(cs_vec),
    .spi_glb_clk_o(glb_clk), .spi_glb_mosi_o(glb_mosi), .spi_4094_strobe_o(strobe),
    .spi_4094_oe_o(oe_4094), .spi_4094_miso_i(miso_4094), .spi_cs_dac_o(cs_dac),
    .spi_cs_iso_o(cs_iso), .hw_flags_i(hw_flags), .trig_i(trig), .leds_o(leds),
    .monitor_o(monitor), .pc_sw_o(pc_sw), .azmux_o(azmux), .adc_refmux_o(refmux),
    .adc_rstmux_o(rstmux), .adc_sigmux_o(sigmux), .adc_cmpr_latch_o(cmpr_latch),
    .spi_interrupt_o(irq)
  );

  always #5 clk = ~clk;   // 100 MHz

  always_comb begin
    pins                    = '0;
    pins[LEDS_LSB +: 4]     = leds;
    pins[MONITOR_LSB +: 8]  = monitor;
    pins[PC_SW_LSB +: 2]    = pc_sw;
    pins[AZMUX_LSB +: 4]    = azmux;
    pins[ADC_REFMUX_LSB +: 2] = refmux;
    pins[ADC_RSTMUX_BIT]    = rstmux;
    pins[ADC_SIGMUX_BIT]    = sigmux;
    pins[CMPR_LATCH_BIT]    = cmpr_latch;
    pins[SPI_INTERRUPT_BIT] = irq;
  end

  // poll the pins until they match and then compare
  task automatic wait_outputs(input logic [OUT_W-1:0] exp, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (pins !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (pins !== exp) begin
      timeout_errors++;
      $display("timeout: output pins did not settle to %h", exp);
    end
    check_outputs("outputs", pins, exp);
  endtask

  initial begin
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] data;
    int               i, c, k, m, nbits, seq_n, samples;
    int               idx, idx_last, rises, pulses, n;
    logic             prev_rst, prev_irq;
    seed      = SEED_INIT;
    clk       = 1'b0;
    reset     = 1'b1;
    sck       = 1'b0;
    sdi       = 1'b0;
    cs_vec    = CS_DEASSERT;
    miso_4094 = 1'b0;
    hw_flags  = '0;
    trig      = 1'b0;
    idx_last  = 0;
    for (i = 0; i < (1 << ADDR_W); i++) shadow[i] = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    //////////////////////////////
    // reset state
    @(negedge clk);
    check_outputs("outputs", pins, '0);
    check_bit("spi_4094_oe", oe_4094, 1'b0);
    for (i = 0; i < 10; i++) begin
      read_reg(RW_REGS[i], rd);
      check_word($sformatf("reg %h", RW_REGS[i]), rd, shadow[RW_REGS[i]]);
    end

    // cs routing over every code incl. unused ones
    for (c = 0; c < 8; c++) begin
      for (k = 0; k < 4; k++) begin
        @(posedge clk);
        cs_vec    <= c;
        sck       <= 1'($random(seed));
        sdi       <= 1'($random(seed));
        miso_4094 <= 1'($random(seed));
        repeat (4) @(posedge clk);   // frame start clears the shift out
        @(negedge clk);
        check_bit("spi_glb_clk", glb_clk, (c == CS_FPGA0) ? 1'b1 : sck);
        check_bit("spi_glb_mosi", glb_mosi, (c == CS_FPGA0) ? 1'b1 : sdi);
        check_bit("spi_4094_strobe", strobe, c == CS_4094);
        check_bit("spi_cs_dac", cs_dac, c != CS_MDAC0);
        check_bit("spi_cs_iso", cs_iso, c != CS_MDAC1);
        check_bit("sdo", sdo, (c == CS_FPGA0) ? 1'b0 : miso_4094);
      end
    end
    @(posedge clk);
    cs_vec <= CS_DEASSERT;
    sck    <= 1'b0;
    sdi    <= 1'b0;

    //////////////////////////////
    // register readback and then cut frames
    for (k = 0; k < 3; k++) begin
      for (i = 0; i < 10; i++) write_reg(RW_REGS[i], $random(seed), FRAME_BITS);
      for (i = 0; i < 10; i++) begin
        read_reg(RW_REGS[i], rd);
        check_word($sformatf("reg %h", RW_REGS[i]), rd, shadow[RW_REGS[i]]);
      end
      check_bit("spi_4094_oe", oe_4094, shadow[REG_4094_OE][0]);
    end
    for (k = 0; k < 6; k++) begin
      i     = {$random(seed)} % 10;
      nbits = 9 + {$random(seed)} % 30;   // 9..38 bits
      write_reg(RW_REGS[i], $random(seed), nbits);
      read_reg(RW_REGS[i], rd);
      check_word($sformatf("reg %h after short frame", RW_REGS[i]), rd, shadow[RW_REGS[i]]);
    end

    // status with an ignored write attempt
    write_reg(REG_STATUS, $random(seed), FRAME_BITS);
    for (k = 0; k < 4; k++) begin
      @(posedge clk);
      hw_flags <= $random(seed);
      read_reg(REG_STATUS, rd);
      check_word("status", rd, status_word(hw_flags, idx_last));
    end

    // direct mode
    write_reg(REG_MODE, REG_W'(MODE_DIRECT), FRAME_BITS);
    for (k = 0; k < 3; k++) begin
      data = $random(seed);
      write_reg(REG_DIRECT, data, FRAME_BITS);
      wait_outputs(data[OUT_W-1:0], OUT_TIMEOUT);
    end

    // unused modes blank everything
    for (m = 1; m < 8; m++) begin
      if (m != MODE_SA_MOCK) begin
        write_reg(REG_MODE, m, FRAME_BITS);
        write_reg(REG_DIRECT, $random(seed), FRAME_BITS);
        wait_outputs('0, OUT_TIMEOUT);
      end
    end

    //////////////////////////////
    // sequencer with mock adc
    seq_n   = 1 + {$random(seed)} % SEQ_ENTRIES;
    samples = 2 * seq_n + {$random(seed)} % 4;
    write_reg(REG_SA_PRECHARGE, 2 + {$random(seed)} % 19, FRAME_BITS);
    write_reg(REG_ADC_APERTURE, 2 + {$random(seed)} % 19, FRAME_BITS);
    write_reg(REG_SA_SEQ_N, seq_n, FRAME_BITS);
    for (i = 0; i < SEQ_ENTRIES; i++) write_reg(REG_SA_SEQ0 + i, $random(seed), FRAME_BITS);
    write_reg(REG_MODE, REG_W'(MODE_SA_MOCK), FRAME_BITS);
    @(posedge clk);
    trig <= 1'b1;
    idx      = 0;
    rises    = 0;
    pulses   = 0;
    n        = 0;
    prev_rst = 1'b0;
    prev_irq = 1'b0;
    while (pulses < samples && n < SEQ_TIMEOUT) begin
      @(negedge clk);
      n++;
      if (monitor[0] && !prev_rst) begin   // adc released with the entry applied
        check_outputs("outputs", pins, sample_vec(idx, shadow[REG_SA_SEQ0 + idx][5:0]));
        rises++;
      end
      if (prev_irq) begin   // interrupt is one clk wide
        check_bit("spi_interrupt", irq, 1'b0);
      end
      if (irq && !prev_irq) begin   // sample done
        pulses++;
        idx_last = idx;
        idx      = next_idx(idx, seq_n);
      end
      prev_rst = monitor[0];
      prev_irq = irq;
    end
    if (pulses < samples) begin
      timeout_errors++;
      $display("timeout: only %0d of %0d samples completed", pulses, samples);
    end
    @(posedge clk);
    trig <= 1'b0;   // lands during precharge so no further sample
    check_word("sample count", rises, pulses);
    read_reg(REG_STATUS, rd);
    check_word("status", rd, status_word(hw_flags, idx_last));

    $display("checks %0d, value errors %0d, timeouts %0d",
             checks, value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+testbench
hdl/dmm_pkg.sv
hdl/sa_params_if.sv
hdl/spi_port.sv
hdl/sequence_acquisition.sv
hdl/adc_mock.sv
hdl/output_mode_mux.sv
hdl/dmm_top.sv
testbench/tb_dmm_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dmm_top -f flist.f
	./obj_dir/Vtb_dmm_top | tee sim.log
	@! grep -q "TEST FAIL" sim.log
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
